//--- Bender.yml
package:
  name: sdmac

sources:
  # RTL in compile order
  - files:
      - hw/sdmacPkg.sv
      - hw/byteFifo.sv
      - hw/periphPortSm.sv
      - hw/sdmacRegs.sv
      - hw/sdmacTop.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/sdmac_asserts.sv
      - tb/tbSdmac.sv

//--- hw/byteFifo.sv
`default_nettype none

module byteFifo #(
    parameter int DEPTH  = sdmacPkg::FIFO_DEPTH_DEF,
    parameter int DATA_W = sdmacPkg::DATA_W
) (
    input  logic                          nSCLK,
    input  logic                          nAS_,
    // CPU side with whole longwords
    input  logic                          cpuPush_i,
    input  logic [DATA_W-1:0]             cpuWdata_i,
    input  logic                          cpuPop_i,
    output logic [DATA_W-1:0]             cpuRdata_o,
    output logic                          empty_o,
    output logic                          full_o,
    input  logic                          flush_i,
    // Device side with single bytes
    input  logic                          devPush_i,
    input  logic [sdmacPkg::BYTE_W-1:0]   devByte_i,
    input  logic                          devPop_i,
    output logic [sdmacPkg::BYTE_W-1:0]   devByte_o,
    output logic                          byteRoom_o,
    output logic                          byteAvail_o,
    input  logic                          endPad_i
);

    localparam int BW    = sdmacPkg::BYTE_W;
    localparam int LANES = DATA_W / BW;
    localparam int OFF_W = $clog2(LANES);
    localparam int AW    = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW:0]       wrPtr;       // Extra bit tells full from empty
    logic [AW:0]       rdPtr;
    logic [OFF_W-1:0]  wrOff;
    logic [OFF_W-1:0]  rdOff;
    logic [DATA_W-1:0] stage;       // Longword being packed
    logic [DATA_W-1:0] stageNext;
    logic [DATA_W-1:0] wrData;
    logic              devWordPush;
    logic              devWordPop;
    logic              wrEn;
    logic              rdEn;

    assign empty_o = (wrPtr == rdPtr);
    assign full_o  = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);

    assign byteRoom_o  = ~full_o;
    assign byteAvail_o = ~empty_o;

    // Big endian packing puts the first byte in the top lane
    always_comb begin
        stageNext = stage;
        stageNext[(LANES-1-int'(wrOff))*BW +: BW] = devByte_i;
    end

    // Push a complete word or a padded partial word at end of transfer
    assign devWordPush = (devPush_i && wrOff == OFF_W'(LANES-1)) ||
                         (endPad_i && wrOff != '0);
    assign devWordPop  = devPop_i && (rdOff == OFF_W'(LANES-1));

    assign wrData = devWordPush ? (devPush_i ? stageNext : stage) : cpuWdata_i;
    assign wrEn   = (cpuPush_i | devWordPush) & ~full_o;
    assign rdEn   = (cpuPop_i | devWordPop) & ~empty_o;

    assign cpuRdata_o = mem[rdPtr[AW-1:0]];
    assign devByte_o  = cpuRdata_o[(LANES-1-int'(rdOff))*BW +: BW];

    always_ff @(posedge nSCLK) begin
        if (wrEn)
            mem[wrPtr[AW-1:0]] <= wrData;
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            wrOff <= '0;
            rdOff <= '0;
            stage <= '0;
        end else if (flush_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            wrOff <= '0;
            rdOff <= '0;
            stage <= '0;
        end else begin
            if (wrEn)
                wrPtr <= wrPtr + 1'b1;
            if (rdEn)
                rdPtr <= rdPtr + 1'b1;

            if (devWordPush) begin
                wrOff <= '0;
                stage <= '0;           // Unused low lanes of the next pad read zero
            end else if (devPush_i) begin
                wrOff <= wrOff + 1'b1;
                stage <= stageNext;
            end

            if (devPop_i)
                rdOff <= rdOff + 1'b1; // Wraps after the last lane
        end
    end

endmodule

`default_nettype wire

//--- hw/periphPortSm.sv
`default_nettype none

module periphPortSm #(
    parameter int STROBE_CYCLES = sdmacPkg::STROBE_DEF
) (
    input  logic                          nSCLK,
    input  logic                          nAS_,
    // Control from the register block
    input  logic                          dmaEna_i,
    input  logic                          dmaDir_i,
    input  logic                          countZero_i,
    // FIFO device side
    input  logic                          byteRoom_i,
    input  logic                          byteAvail_i,
    output logic                          devPush_o,
    output logic                          devPop_o,
    output logic [sdmacPkg::BYTE_W-1:0]   devByte_o,
    input  logic [sdmacPkg::BYTE_W-1:0]   devByte_i,
    output logic                          endPad_o,
    // Count
    output logic                          byteDone_o,
    // Peripheral port
    input  logic                          nDreq_i,
    output logic                          nDack_o,
    output logic                          nIor_o,
    output logic                          nIow_o,
    input  logic [sdmacPkg::BYTE_W-1:0]   pdData_i,
    output logic [sdmacPkg::BYTE_W-1:0]   pdData_o,
    output logic                          pdOe_o
);

    localparam int STB_W = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        RECOVER
    } stateT;

    stateT            state;
    logic [STB_W-1:0] stbCnt;
    logic             cycDir;   // Direction latched for the running cycle
    logic             startCyc;
    logic             lastStb;
    logic             padPend;

    // Start only with DREQ, a live count and room or data in the FIFO
    assign startCyc = (state == IDLE) && !nDreq_i && dmaEna_i && !countZero_i &&
                      (dmaDir_i ? byteRoom_i : byteAvail_i);

    assign lastStb = (state == STROBE) && (stbCnt == STB_W'(STROBE_CYCLES - 1));

    assign byteDone_o = lastStb;
    assign devPush_o  = lastStb & cycDir;   // Capture at the last strobe edge
    assign devPop_o   = lastStb & ~cycDir;
    assign devByte_o  = pdData_i;

    // Count just hit zero after a device byte so the FIFO pads a partial word
    assign endPad_o = padPend & countZero_i;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state   <= IDLE;
            stbCnt  <= '0;
            cycDir  <= 1'b0;
            padPend <= 1'b0;
            nDack_o <= 1'b1;
            nIor_o  <= 1'b1;
            nIow_o  <= 1'b1;
            pdOe_o  <= 1'b0;
        end else begin
            padPend <= devPush_o;
            case (state)
                IDLE: begin
                    if (startCyc) begin
                        state   <= STROBE;
                        stbCnt  <= '0;
                        cycDir  <= dmaDir_i;
                        nDack_o <= 1'b0;
                        nIor_o  <= ~dmaDir_i;   // Read from chip
                        nIow_o  <= dmaDir_i;    // Write to chip
                        pdOe_o  <= ~dmaDir_i;
                    end
                end
                STROBE: begin
                    if (lastStb) begin
                        state   <= RECOVER;
                        nDack_o <= 1'b1;
                        nIor_o  <= 1'b1;
                        nIow_o  <= 1'b1;
                        pdOe_o  <= 1'b0;
                    end else begin
                        stbCnt <= stbCnt + 1'b1;
                    end
                end
                RECOVER: state <= IDLE;   // One cycle with all strobes high
                default: state <= IDLE;
            endcase
        end
    end

    // Head byte held on the port for the whole write strobe
    always_ff @(posedge nSCLK) begin
        if (startCyc)
            pdData_o <= devByte_i;
    end

endmodule

`default_nettype wire

//--- hw/sdmacPkg.sv
`default_nettype none

package sdmacPkg;

    // Bus and counter widths
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int ADDR_W = 4;
    localparam int CNT_W  = 16;

    // Register byte offsets on the APB side
    localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [ADDR_W-1:0] REG_DATA   = 4'h8;
    localparam logic [ADDR_W-1:0] REG_COUNT  = 4'hC;

    // CTRL bits
    localparam int CTRL_ENA    = 0;
    localparam int CTRL_DIR    = 1;  // 1 = device to memory
    localparam int CTRL_FLUSH  = 2;  // Self clearing and reads as 0
    localparam int CTRL_INTENA = 3;

    // STATUS bits
    localparam int ST_EMPTY = 0;  // No whole longword for the CPU
    localparam int ST_FULL  = 1;
    localparam int ST_INTA  = 2;  // SCSI chip interrupt line
    localparam int ST_DONE  = 3;

    // Defaults used by the top level
    localparam int FIFO_DEPTH_DEF = 8;
    localparam int STROBE_DEF     = 3;

endpackage

`default_nettype wire

//--- hw/sdmacRegs.sv
`default_nettype none

module sdmacRegs #(
    parameter int CNT_W = sdmacPkg::CNT_W
) (
    input  logic                          nSCLK,
    input  logic                          nAS_,
    // APB slave
    input  logic                          pSel_i,
    input  logic                          pEnable_i,
    input  logic                          pWrite_i,
    input  logic [sdmacPkg::ADDR_W-1:0]   pAddr_i,
    input  logic [sdmacPkg::DATA_W-1:0]   pWdata_i,
    output logic [sdmacPkg::DATA_W-1:0]   pRdata_o,
    output logic                          pReady_o,
    output logic                          pSlvErr_o,
    // FIFO CPU side
    input  logic                          empty_i,
    input  logic                          full_i,
    input  logic [sdmacPkg::DATA_W-1:0]   cpuRdata_i,
    output logic                          cpuPush_o,
    output logic                          cpuPop_o,
    output logic [sdmacPkg::DATA_W-1:0]   cpuWdata_o,
    output logic                          flush_o,
    // Sequencer
    input  logic                          byteDone_i,
    output logic                          dmaEna_o,
    output logic                          dmaDir_o,
    output logic                          countZero_o,
    // Interrupt
    input  logic                          inta_i,
    output logic                          nInt_o
);

    logic accPhase;
    logic wrAcc;
    logic rdAcc;
    logic selCtrl;
    logic selStatus;
    logic selData;
    logic selCount;
    logic ctrlEna;
    logic ctrlDir;
    logic ctrlIntEna;
    logic dmaDone;
    logic [CNT_W-1:0] byteCount;
    logic [sdmacPkg::DATA_W-1:0] ctrlWord;
    logic [sdmacPkg::DATA_W-1:0] statusWord;
    logic [sdmacPkg::DATA_W-1:0] countWord;

    // No wait states so every access phase completes at once
    assign accPhase = pSel_i & pEnable_i;
    assign wrAcc    = accPhase & pWrite_i;
    assign rdAcc    = accPhase & ~pWrite_i;
    assign pReady_o = accPhase;

    assign selCtrl   = (pAddr_i == sdmacPkg::REG_CTRL);
    assign selStatus = (pAddr_i == sdmacPkg::REG_STATUS);
    assign selData   = (pAddr_i == sdmacPkg::REG_DATA);
    assign selCount  = (pAddr_i == sdmacPkg::REG_COUNT);

    // Data port refuses when the FIFO cannot take or give a longword
    assign pSlvErr_o  = selData & ((wrAcc & full_i) | (rdAcc & empty_i));
    assign cpuPush_o  = wrAcc & selData & ~full_i;
    assign cpuPop_o   = rdAcc & selData & ~empty_i;
    assign cpuWdata_o = pWdata_i;
    assign flush_o    = wrAcc & selCtrl & pWdata_i[sdmacPkg::CTRL_FLUSH];

    assign dmaEna_o    = ctrlEna;
    assign dmaDir_o    = ctrlDir;
    assign countZero_o = (byteCount == '0);

    always_comb begin
        ctrlWord = '0;
        ctrlWord[sdmacPkg::CTRL_ENA]    = ctrlEna;
        ctrlWord[sdmacPkg::CTRL_DIR]    = ctrlDir;
        ctrlWord[sdmacPkg::CTRL_INTENA] = ctrlIntEna;

        statusWord = '0;
        statusWord[sdmacPkg::ST_EMPTY] = empty_i;
        statusWord[sdmacPkg::ST_FULL]  = full_i;
        statusWord[sdmacPkg::ST_INTA]  = inta_i;
        statusWord[sdmacPkg::ST_DONE]  = dmaDone;

        countWord = '0;
        countWord[CNT_W-1:0] = byteCount;

        pRdata_o = '0;
        if (rdAcc) begin
            if (selCtrl)
                pRdata_o = ctrlWord;
            else if (selStatus)
                pRdata_o = statusWord;
            else if (selData)
                pRdata_o = cpuRdata_i;  // Head longword
            else if (selCount)
                pRdata_o = countWord;
        end
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            ctrlEna    <= 1'b0;
            ctrlDir    <= 1'b0;
            ctrlIntEna <= 1'b0;
            byteCount  <= '0;
            dmaDone    <= 1'b0;
            nInt_o     <= 1'b1;
        end else begin
            if (wrAcc && selCtrl) begin
                ctrlEna    <= pWdata_i[sdmacPkg::CTRL_ENA];
                ctrlDir    <= pWdata_i[sdmacPkg::CTRL_DIR];
                ctrlIntEna <= pWdata_i[sdmacPkg::CTRL_INTENA];
            end

            if (wrAcc && selCount) begin
                byteCount <= pWdata_i[CNT_W-1:0];
                dmaDone   <= 1'b0;      // New transfer
            end else if (byteDone_i && !countZero_o) begin
                byteCount <= byteCount - 1'b1;
                // Last byte of the transfer moved
                if (byteCount == CNT_W'(1) && ctrlEna)
                    dmaDone <= 1'b1;
            end

            nInt_o <= ~(ctrlIntEna & (inta_i | dmaDone));
        end
    end

endmodule

`default_nettype wire

//--- hw/sdmacTop.sv
`default_nettype none

module sdmacTop #(
    parameter int FIFO_DEPTH    = sdmacPkg::FIFO_DEPTH_DEF,
    parameter int STROBE_CYCLES = sdmacPkg::STROBE_DEF
) (
    input  logic                          nSCLK,
    input  logic                          nAS_,
    // APB
    input  logic                          pSel_i,
    input  logic                          pEnable_i,
    input  logic                          pWrite_i,
    input  logic [sdmacPkg::ADDR_W-1:0]   pAddr_i,
    input  logic [sdmacPkg::DATA_W-1:0]   pWdata_i,
    output logic [sdmacPkg::DATA_W-1:0]   pRdata_o,
    output logic                          pReady_o,
    output logic                          pSlvErr_o,
    // SCSI peripheral port
    input  logic                          nDreq_i,
    output logic                          nDack_o,
    output logic                          nIor_o,
    output logic                          nIow_o,
    input  logic [sdmacPkg::BYTE_W-1:0]   pdData_i,
    output logic [sdmacPkg::BYTE_W-1:0]   pdData_o,
    output logic                          pdOe_o,
    input  logic                          inta_i,
    output logic                          nInt_o
);

    logic                        cpuPush;
    logic                        cpuPop;
    logic [sdmacPkg::DATA_W-1:0] cpuWdata;
    logic [sdmacPkg::DATA_W-1:0] cpuRdata;
    logic                        flush;
    logic                        empty;
    logic                        full;
    logic                        devPush;
    logic                        devPop;
    logic [sdmacPkg::BYTE_W-1:0] devWrByte;  // Sequencer to FIFO
    logic [sdmacPkg::BYTE_W-1:0] devRdByte;  // FIFO to sequencer
    logic                        byteRoom;
    logic                        byteAvail;
    logic                        endPad;
    logic                        dmaEna;
    logic                        dmaDir;
    logic                        countZero;
    logic                        byteDone;

    sdmacRegs #(
        .CNT_W (sdmacPkg::CNT_W)
    ) i_sdmacRegs (
        .nSCLK       (nSCLK),
        .nAS_        (nAS_),
        .pSel_i      (pSel_i),
        .pEnable_i   (pEnable_i),
        .pWrite_i    (pWrite_i),
        .pAddr_i     (pAddr_i),
        .pWdata_i    (pWdata_i),
        .pRdata_o    (pRdata_o),
        .pReady_o    (pReady_o),
        .pSlvErr_o   (pSlvErr_o),
        .empty_i     (empty),
        .full_i      (full),
        .cpuRdata_i  (cpuRdata),
        .cpuPush_o   (cpuPush),
        .cpuPop_o    (cpuPop),
        .cpuWdata_o  (cpuWdata),
        .flush_o     (flush),
        .byteDone_i  (byteDone),
        .dmaEna_o    (dmaEna),
        .dmaDir_o    (dmaDir),
        .countZero_o (countZero),
        .inta_i      (inta_i),
        .nInt_o      (nInt_o)
    );

    byteFifo #(
        .DEPTH  (FIFO_DEPTH),
        .DATA_W (sdmacPkg::DATA_W)
    ) i_byteFifo (
        .nSCLK       (nSCLK),
        .nAS_        (nAS_),
        .cpuPush_i   (cpuPush),
        .cpuWdata_i  (cpuWdata),
        .cpuPop_i    (cpuPop),
        .cpuRdata_o  (cpuRdata),
        .empty_o     (empty),
        .full_o      (full),
        .flush_i     (flush),
        .devPush_i   (devPush),
        .devByte_i   (devWrByte),
        .devPop_i    (devPop),
        .devByte_o   (devRdByte),
        .byteRoom_o  (byteRoom),
        .byteAvail_o (byteAvail),
        .endPad_i    (endPad)
    );

    periphPortSm #(
        .STROBE_CYCLES (STROBE_CYCLES)
    ) i_periphPortSm (
        .nSCLK       (nSCLK),
        .nAS_        (nAS_),
        .dmaEna_i    (dmaEna),
        .dmaDir_i    (dmaDir),
        .countZero_i (countZero),
        .byteRoom_i  (byteRoom),
        .byteAvail_i (byteAvail),
        .devPush_o   (devPush),
        .devPop_o    (devPop),
        .devByte_o   (devWrByte),
        .devByte_i   (devRdByte),
        .endPad_o    (endPad),
        .byteDone_o  (byteDone),
        .nDreq_i     (nDreq_i),
        .nDack_o     (nDack_o),
        .nIor_o      (nIor_o),
        .nIow_o      (nIow_o),
        .pdData_i    (pdData_i),
        .pdData_o    (pdData_o),
        .pdOe_o      (pdOe_o)
    );

endmodule

`default_nettype wire

//--- tb.f
hw/sdmacPkg.sv
hw/byteFifo.sv
hw/periphPortSm.sv
hw/sdmacRegs.sv
hw/sdmacTop.sv
tb/sdmac_asserts.sv
tb/tbSdmac.sv

//--- tb/sdmac_asserts.sv
`default_nettype none

module sdmacAsserts (
    input  logic nSCLK,
    input  logic nAS_,
    input  logic nDack_i,
    input  logic nIor_i,
    input  logic nIow_i,
    input  logic pdOe_i,
    input  logic countZero_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount;  // Read by the testbench at the end

    initial failCount = 0;

    aNoDualStrobe: assert property (@(posedge nSCLK) disable iff (!nAS_)
        !(!nIor_i && !nIow_i))
        else begin
            $error("nIor and nIow low together");
            failCount++;
        end

    // A strobe never runs without DACK
    aStrobeDack: assert property (@(posedge nSCLK) disable iff (!nAS_)
        (!nIor_i || !nIow_i) |-> !nDack_i)
        else begin
            $error("Strobe low without nDack");
            failCount++;
        end

    aOeOnWrite: assert property (@(posedge nSCLK) disable iff (!nAS_)
        pdOe_i |-> !nIow_i)
        else begin
            $error("pdOe outside a write strobe");
            failCount++;
        end

    aNoStartAtZero: assert property (@(posedge nSCLK) disable iff (!nAS_)
        $fell(nDack_i) |-> !$past(countZero_i))   // Count seen at the start edge
        else begin
            $error("Byte cycle started with a zero count");
            failCount++;
        end

endmodule

bind periphPortSm sdmacAsserts i_sdmacAsserts (
    .nSCLK       (nSCLK),
    .nAS_        (nAS_),
    .nDack_i     (nDack_o),
    .nIor_i      (nIor_o),
    .nIow_i      (nIow_o),
    .pdOe_i      (pdOe_o),
    .countZero_i (countZero_i)
);

`default_nettype wire

//--- tb/tbSdmac.sv
`default_nettype none

module tbSdmac;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH = sdmacPkg::FIFO_DEPTH_DEF;
    localparam int STROBE     = sdmacPkg::STROBE_DEF;
    localparam int MAX_GAP    = 6;      // Longest DREQ gap of the device model
    localparam int MAX_BYTES  = 24 + 24 + 4 * FIFO_DEPTH + 7 + 1;
    localparam int TIMEOUT_NS = (MAX_BYTES * (STROBE + 2 + MAX_GAP) + 4000) * 8;

    logic                        nSCLK;
    logic                        nAS_;
    logic                        pSel_i;
    logic                        pEnable_i;
    logic                        pWrite_i;
    logic [sdmacPkg::ADDR_W-1:0] pAddr_i;
    logic [sdmacPkg::DATA_W-1:0] pWdata_i;
    logic [sdmacPkg::DATA_W-1:0] pRdata_o;
    logic                        pReady_o;
    logic                        pSlvErr_o;
    logic                        nDreq_i;
    logic                        nDack_o;
    logic                        nIor_o;
    logic                        nIow_o;
    logic [sdmacPkg::BYTE_W-1:0] pdData_i;
    logic [sdmacPkg::BYTE_W-1:0] pdData_o;
    logic                        pdOe_o;
    logic                        inta_i;
    logic                        nInt_o;

    logic       devEnable;      // Device model raises DREQ only when set
    logic [7:0] iorBytes[$];    // Bytes handed out on nIor
    logic [7:0] iowBytes[$];    // Bytes seen on nIow

    sdmacTop #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .STROBE_CYCLES (STROBE)
    ) i_sdmacTop (
        .nSCLK     (nSCLK),
        .nAS_      (nAS_),
        .pSel_i    (pSel_i),
        .pEnable_i (pEnable_i),
        .pWrite_i  (pWrite_i),
        .pAddr_i   (pAddr_i),
        .pWdata_i  (pWdata_i),
        .pRdata_o  (pRdata_o),
        .pReady_o  (pReady_o),
        .pSlvErr_o (pSlvErr_o),
        .nDreq_i   (nDreq_i),
        .nDack_o   (nDack_o),
        .nIor_o    (nIor_o),
        .nIow_o    (nIow_o),
        .pdData_i  (pdData_i),
        .pdData_o  (pdData_o),
        .pdOe_o    (pdOe_o),
        .inta_i    (inta_i),
        .nInt_o    (nInt_o)
    );

    initial begin
        nSCLK = 1'b0;
        forever #4 nSCLK = ~nSCLK;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** FAILED ***");
        $fatal(1, "Simulation timed out");
    end

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic logic [31:0] ctrlValue(logic ena, logic dir, logic intEna, logic flush);
        logic [31:0] v;
        v = '0;
        v[sdmacPkg::CTRL_ENA]    = ena;
        v[sdmacPkg::CTRL_DIR]    = dir;
        v[sdmacPkg::CTRL_INTENA] = intEna;
        v[sdmacPkg::CTRL_FLUSH]  = flush;
        return v;
    endfunction

    // Big endian longword from the device bytes with missing lanes zero
    function automatic logic [31:0] packWord(int idx);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 4; b++) begin
            if (4 * idx + b < iorBytes.size())
                w[31-8*b -: 8] = iorBytes[4*idx+b];
        end
        return w;
    endfunction

    // Both tasks start and end 1 ns after a rising edge
    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, input logic expErr);
        pSel_i    = 1'b1;
        pEnable_i = 1'b0;
        pWrite_i  = 1'b1;
        pAddr_i   = addr;
        pWdata_i  = data;
        @(posedge nSCLK);
        #1;
        pEnable_i = 1'b1;
        @(negedge nSCLK);   // Mid access phase
        checkEq(pReady_o, 1'b1, "PREADY on write");
        checkEq(pSlvErr_o, expErr, $sformatf("PSLVERR on write to %h", addr));
        @(posedge nSCLK);
        #1;
        pSel_i    = 1'b0;
        pEnable_i = 1'b0;
        pWrite_i  = 1'b0;
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, input logic expErr);
        pSel_i    = 1'b1;
        pEnable_i = 1'b0;
        pWrite_i  = 1'b0;
        pAddr_i   = addr;
        @(posedge nSCLK);
        #1;
        pEnable_i = 1'b1;
        @(negedge nSCLK);
        checkEq(pReady_o, 1'b1, "PREADY on read");
        checkEq(pSlvErr_o, expErr, $sformatf("PSLVERR on read of %h", addr));
        data = pRdata_o;
        @(posedge nSCLK);
        #1;
        pSel_i    = 1'b0;
        pEnable_i = 1'b0;
    endtask

    task automatic drainWords(input int nWords);
        logic [31:0] rd;
        for (int i = 0; i < nWords; i++) begin
            rd = 32'd1 << sdmacPkg::ST_EMPTY;
            while (rd[sdmacPkg::ST_EMPTY])
                apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
            apbRead(sdmacPkg::REG_DATA, rd, 1'b0);
            checkEq(rd, packWord(i), $sformatf("longword %0d from DATA", i));
        end
    endtask

    task automatic runDevToMem(input int count, input logic intEna, input logic holdOff);
        logic [31:0] rd;
        iorBytes.delete();
        apbWrite(sdmacPkg::REG_COUNT, count, 1'b0);
        apbWrite(sdmacPkg::REG_CTRL, ctrlValue(1'b1, 1'b1, intEna, 1'b0), 1'b0);
        devEnable = 1'b1;
        if (holdOff) begin
            rd = '0;
            while (!rd[sdmacPkg::ST_FULL])
                apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
            repeat (4 * (STROBE + 2 + MAX_GAP)) begin
                @(posedge nSCLK);
                #1;
                checkEq(nDack_o, 1'b1, "nDack while FIFO full");
            end
            checkEq(iorBytes.size(), 4 * FIFO_DEPTH, "bytes moved before full");
        end
        drainWords((count + 3) / 4);
        checkEq(iorBytes.size(), count, "bytes read from the device");
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, (32'd1 << sdmacPkg::ST_EMPTY) | (32'd1 << sdmacPkg::ST_DONE),
                "status after device to memory");
        apbRead(sdmacPkg::REG_COUNT, rd, 1'b0);
        checkEq(rd, 32'd0, "count after device to memory");
        devEnable = 1'b0;
        apbWrite(sdmacPkg::REG_CTRL, ctrlValue(1'b0, 1'b1, intEna, 1'b0), 1'b0);
    endtask

    task automatic runMemToDev(input int count);
        logic [31:0] w;
        logic [31:0] rd;
        logic [7:0]  expBytes[$];
        iowBytes.delete();
        apbWrite(sdmacPkg::REG_COUNT, count, 1'b0);
        apbWrite(sdmacPkg::REG_CTRL, ctrlValue(1'b1, 1'b0, 1'b0, 1'b0), 1'b0);
        devEnable = 1'b1;
        for (int i = 0; i < (count + 3) / 4; i++) begin
            w = $urandom;
            apbWrite(sdmacPkg::REG_DATA, w, 1'b0);
            for (int b = 0; b < 4; b++)
                expBytes.push_back(w[31-8*b -: 8]);     // MSB leaves first
        end
        while (iowBytes.size() < count) begin
            @(posedge nSCLK);
            #1;
        end
        repeat (2 * (STROBE + 2 + MAX_GAP)) @(posedge nSCLK);  // No extra bytes
        #1;
        checkEq(iowBytes.size(), count, "bytes written to the device");
        for (int i = 0; i < count; i++)
            checkEq(iowBytes[i], expBytes[i], $sformatf("device byte %0d", i));
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd[sdmacPkg::ST_DONE], 1'b1, "ST_DONE after memory to device");
        devEnable = 1'b0;
        apbWrite(sdmacPkg::REG_CTRL, ctrlValue(1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, (32'd1 << sdmacPkg::ST_EMPTY) | (32'd1 << sdmacPkg::ST_DONE),
                "status after flush");
    endtask

    task automatic checkErrorsAndFlush();
        logic [31:0] rd;
        logic [31:0] first;
        apbWrite(sdmacPkg::REG_COUNT, 32'd0, 1'b0);    // Also clears ST_DONE
        apbWrite(sdmacPkg::REG_CTRL, 32'd0, 1'b0);
        apbRead(sdmacPkg::REG_DATA, rd, 1'b1);         // Refused while empty
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, 32'd1 << sdmacPkg::ST_EMPTY, "status after refused read");
        first = $urandom;
        apbWrite(sdmacPkg::REG_DATA, first, 1'b0);
        for (int i = 1; i < FIFO_DEPTH; i++)
            apbWrite(sdmacPkg::REG_DATA, $urandom, 1'b0);
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, 32'd1 << sdmacPkg::ST_FULL, "status when full");
        apbWrite(sdmacPkg::REG_DATA, ~first, 1'b1);    // Refused while full
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, 32'd1 << sdmacPkg::ST_FULL, "status after refused write");
        apbRead(sdmacPkg::REG_DATA, rd, 1'b0);
        checkEq(rd, first, "head longword after refused write");
        apbWrite(sdmacPkg::REG_CTRL, ctrlValue(1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, 32'd1 << sdmacPkg::ST_EMPTY, "status after flush");
        apbRead(sdmacPkg::REG_CTRL, rd, 1'b0);
        checkEq(rd, 32'd0, "CTRL readback after flush");
    endtask

    // SCSI chip side acting 1 ns after each rising edge
    initial begin : deviceModel
        int   gap;
        logic busy;
        nDreq_i  = 1'b1;
        pdData_i = '0;
        gap      = 0;
        busy     = 1'b0;
        forever begin
            @(posedge nSCLK);
            #1;
            if (!nDack_o) begin
                if (!busy) begin    // First strobe cycle of a byte
                    busy    = 1'b1;
                    nDreq_i = 1'b1;
                    if (!nIor_o)
                        iorBytes.push_back(pdData_i);
                    if (!nIow_o)
                        iowBytes.push_back(pdData_o);
                    gap = $urandom_range(MAX_GAP, 0);
                end
                // Output enable and write byte held over the whole strobe
                checkEq(pdOe_o, !nIow_o, "pdOe during a strobe");
                if (!nIow_o)
                    checkEq(pdData_o, iowBytes[$], "pdData over the write strobe");
            end else begin
                busy = 1'b0;
                if (!devEnable) begin
                    nDreq_i = 1'b1;
                end else if (nDreq_i) begin
                    if (gap == 0) begin
                        nDreq_i  = 1'b0;
                        pdData_i = 8'($urandom);
                    end else begin
                        gap--;
                    end
                end
            end
        end
    end

    initial begin : mainFlow
        logic [31:0] rd;
        void'($urandom(32'h708));
        nAS_      = 1'b0;
        pSel_i    = 1'b0;
        pEnable_i = 1'b0;
        pWrite_i  = 1'b0;
        pAddr_i   = '0;
        pWdata_i  = '0;
        inta_i    = 1'b0;
        devEnable = 1'b0;
        repeat (5) @(posedge nSCLK);
        #1;
        nAS_ = 1'b1;
        @(posedge nSCLK);
        #1;

        // Reset state
        checkEq({nDack_o, nIor_o, nIow_o, nInt_o}, 4'hF, "strobes and nInt after reset");
        checkEq({pdOe_o, pReady_o}, 2'b00, "pdOe and PREADY after reset");
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd, 32'd1 << sdmacPkg::ST_EMPTY, "status after reset");

        runDevToMem($urandom_range(24, 1), 1'b0, 1'b0);
        runMemToDev($urandom_range(24, 1));
        runDevToMem(4 * FIFO_DEPTH + $urandom_range(7, 1), 1'b0, 1'b1);  // Back-pressure
        checkErrorsAndFlush();

        // Interrupt from INTA and then from ST_DONE
        apbWrite(sdmacPkg::REG_CTRL, ctrlValue(1'b0, 1'b0, 1'b1, 1'b0), 1'b0);
        checkEq(nInt_o, 1'b1, "nInt with no source");
        inta_i = 1'b1;
        @(posedge nSCLK);
        #1;
        checkEq(nInt_o, 1'b0, "nInt follows INTA");
        apbRead(sdmacPkg::REG_STATUS, rd, 1'b0);
        checkEq(rd[sdmacPkg::ST_INTA], 1'b1, "ST_INTA");
        inta_i = 1'b0;
        @(posedge nSCLK);
        #1;
        checkEq(nInt_o, 1'b1, "nInt after INTA drops");
        runDevToMem(1, 1'b1, 1'b0);
        checkEq(nInt_o, 1'b0, "nInt on ST_DONE");
        apbWrite(sdmacPkg::REG_COUNT, 32'd0, 1'b0);
        @(posedge nSCLK);
        #1;
        checkEq(nInt_o, 1'b1, "nInt after ST_DONE cleared");
        apbWrite(sdmacPkg::REG_CTRL, 32'd0, 1'b0);
        inta_i = 1'b1;
        repeat (4) begin
            @(posedge nSCLK);
            #1;
            checkEq(nInt_o, 1'b1, "nInt with interrupts disabled");
        end
        inta_i = 1'b0;

        if (i_sdmacTop.i_periphPortSm.i_sdmacAsserts.failCount != 0) begin
            $display("Assertion failures seen: %0d",
                     i_sdmacTop.i_periphPortSm.i_sdmacAsserts.failCount);
            $display("*** FAILED ***");
            $fatal(1, "Assertions failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
